// File: common/bs_fixed_pkg.sv
`default_nettype none

package bs_fixed_pkg;

	// Strike K, signed (8,15).
	typedef logic signed [22:0] strike_t;
	// S times exp((r - sigma^2/2)T), unsigned (23,15).
	typedef logic [37:0] drift_t;
	// Sigma times sqrt(T), unsigned (3,15).
	typedef logic [17:0] vol_t;
	// Normal variate, signed (5,15).
	typedef logic signed [19:0] grn_t;

	// Volatility product, signed (8,30).
	typedef logic signed [37:0] z_t;
	// Table output, (9,31).
	typedef logic [39:0] exp_t;
	// One plus 13 fraction bits, (2,15).
	typedef logic [16:0] mant_t;
	// Corrected exponential, (11,46).
	typedef logic [56:0] exp_prod_t;
	// Scaled price, (34,61).
	typedef logic [94:0] price_prod_t;

	// Payoff sum, (40,15) zero-extended.
	typedef logic [63:0] sum_t;

	// Range of the exponent.
	// High and low are overridden by the payoff clamp.
	typedef enum logic [1:0] {
		RANGE_HIGH = 2'd0,
		RANGE_MID  = 2'd1,
		RANGE_LOW  = 2'd2
	} range_t;

	// Integer bounds of the middle band.
	localparam int Z_LOW_LIMIT = -19;
	localparam int Z_HIGH_LIMIT = 5;

endpackage

`default_nettype wire

// File: common/bs_ctrl_pkg.sv
`default_nettype none

package bs_ctrl_pkg;

	// Host commands.
	typedef enum logic [3:0] {
		CMD_NONE = 4'd0,
		CMD_RUN  = 4'd1,
		CMD_ACK  = 4'd2
	} cmd_t;

	// Processor status, as seen by the host.
	typedef enum logic [3:0] {
		ST_IDLE     = 4'd0,
		ST_RUNNING  = 4'd1,
		ST_COMPLETE = 4'd2
	} state_t;

	// Width of the iteration count.
	localparam int NITER_W_DEFAULT = 32;

endpackage

`default_nettype wire

// File: common/bs_if.sv
`default_nettype none

// Run constants from the controller to the datapath.
interface cfg_if import bs_fixed_pkg::*; ();

	strike_t strike;
	drift_t drift;
	vol_t vol;
	grn_t grn;

	// Controller owns all fields.
	modport ctrl (output strike, drift, vol, grn);
	// Exponential chain needs drift, vol and variate.
	modport pipe (input drift, vol, grn);
	// Payoff stage needs only the strike.
	modport acc (input strike);

endinterface

// One price beat per cycle, no handshake.
interface price_if import bs_fixed_pkg::*; ();

	logic valid;
	// May arrive alone on an empty run.
	logic last;
	price_prod_t price;
	range_t range;

	modport src (output valid, last, price, range);
	modport dst (input valid, last, price, range);

endinterface

`default_nettype wire

// File: exp_pipeline/exp_lut.sv
`default_nettype none

module exp_lut import bs_fixed_pkg::*; (
	input logic signed [7:0] index,
	output exp_t value
);

	// Index bounds in quarter steps, -21.25 up to 5.
	localparam int LUT_MIN = -85;
	localparam int LUT_MAX = 20;
	localparam int LUT_DEPTH = LUT_MAX - LUT_MIN + 1;

	// e to the power index/4, (9,31), from the lowest index up.
	localparam exp_t EXP_TABLE [LUT_DEPTH] = '{
		40'h0000000001, 40'h0000000001, 40'h0000000002, 40'h0000000002, 40'h0000000003,
		40'h0000000004, 40'h0000000005, 40'h0000000007, 40'h0000000009, 40'h000000000C,
		40'h000000000F, 40'h0000000013, 40'h0000000019, 40'h0000000020, 40'h0000000029,
		40'h0000000035, 40'h0000000045, 40'h0000000058, 40'h0000000072, 40'h0000000092,
		40'h00000000BC, 40'h00000000F1, 40'h0000000136, 40'h000000018E, 40'h00000001FF,
		40'h0000000290, 40'h000000034B, 40'h000000043B, 40'h000000056E, 40'h00000006F9,
		40'h00000008F4, 40'h0000000B80, 40'h0000000EC4, 40'h00000012F6, 40'h0000001858,
		40'h0000001F42, 40'h0000002823, 40'h000000338A, 40'h000000422E, 40'h00000054FA,
		40'h0000006D1C, 40'h0000008C1A, 40'h000000B3E5, 40'h000000E6FE, 40'h0000012899,
		40'h0000017CD7, 40'h000001E902, 40'h00000273E7, 40'h000003263E, 40'h0000040B3C,
		40'h0000053145, 40'h000006AAD0, 40'h0000088F98, 40'h00000AFE10, 40'h00000E1D54,
		40'h0000121F9B, 40'h000017455F, 40'h00001DE16B, 40'h0000265E0C, 40'h00003143C3,
		40'h00003F41D2, 40'h0000513947, 40'h0000684B19, 40'h000085EA52, 40'h0000ABF35F,
		40'h0000DCC9FF, 40'h00011B7FAD, 40'h00016C0504, 40'h0001D36911, 40'h0002582AB7,
		40'h000302A126, 40'h0003DD8203, 40'h0004F68DA1, 40'h00065F6C33, 40'h00082EC9C4,
		40'h000A81C2E0, 40'h000D7DB8C7, 40'h001152AAA3, 40'h00163E397E, 40'h001C8F8772,
		40'h0024AC306E, 40'h002F16AC6C, 40'h003C7681D7, 40'h004DA2CBF1, 40'h0063AFBE7A,
		40'h0080000000, 40'h00A45AF1E1, 40'h00D3094C70, 40'h010EF9DB46, 40'h015BF0A8B1,
		40'h01BEC38EDB, 40'h023DA7FCC9, 40'h02E096D20B, 40'h03B1CC971A, 40'h04BE6E20BD,
		40'h06175BF64C, 40'h07D241C2F6, 40'h0A0AF2DFB7, 40'h0CE529DBC0, 40'h108EC72139,
		40'h1542B2D0A2, 40'h1B4C902E27, 40'h230D7E26DA, 40'h2D02315BC3, 40'h39CAC9D5DB,
		40'h4A34E265C0
	};

	// Table slot, offset from the lowest index.
	logic [6:0] slot;

	assign slot = 7'(int'(index) - LUT_MIN);

	// Out of range gives zero.
	always_comb begin
		if ((index >= LUT_MIN) && (index <= LUT_MAX)) begin
			value = EXP_TABLE[slot];
		end else begin
			value = '0;
		end
	end

endmodule

`default_nettype wire

// File: exp_pipeline/exp_pipeline.sv
`default_nettype none

module exp_pipeline import bs_fixed_pkg::*; (
	input logic clk,
	input logic nreset,
	input logic issue,
	input logic last,
	cfg_if.pipe cfg,
	price_if.src price
);

	// Stage 1 results.
	z_t z_q;
	logic valid1_q;
	logic last1_q;
	// Stage 2 results.
	exp_prod_t exp_q;
	range_t range2_q;
	logic valid2_q;
	logic last2_q;

	// Integer part of the product, for the range class.
	logic signed [7:0] z_int;
	exp_t lut_value;
	mant_t mant;
	range_t range1;

	assign z_int = z_q[37:30];
	// Linear correction, one plus the 13 bits below the table index.
	assign mant = {2'b01, 2'b00, z_q[27:15]};

	// Table indexed by the (6,2) bits of the product.
	exp_lut i_exp_lut (
		.index(z_q[35:28]),
		.value(lut_value)
	);

	// Range class.
	always_comb begin
		if (z_int < Z_LOW_LIMIT) begin
			range1 = RANGE_LOW;
		end else if (z_int < Z_HIGH_LIMIT) begin
			range1 = RANGE_MID;
		end else begin
			range1 = RANGE_HIGH;
		end
	end

	// Flags, cleared on reset.
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			valid1_q <= 1'b0;
			last1_q <= 1'b0;
			valid2_q <= 1'b0;
			last2_q <= 1'b0;
			price.valid <= 1'b0;
			price.last <= 1'b0;
		end else begin
			valid1_q <= issue;
			last1_q <= last;
			valid2_q <= valid1_q;
			last2_q <= last1_q;
			price.valid <= valid2_q;
			price.last <= last2_q;
		end
	end

	// Datapath.
	always_ff @(posedge clk) begin
		// Unsigned vol times signed variate, (8,30).
		z_q <= $signed({1'b0, cfg.vol}) * cfg.grn;
		// Approximate exp, (11,46).
		exp_q <= lut_value * mant;
		range2_q <= range1;
		// Scaled price, (34,61).
		price.price <= exp_q * cfg.drift;
		price.range <= range2_q;
	end

endmodule

`default_nettype wire

// File: hw/run_control.sv
`default_nettype none

module run_control import bs_fixed_pkg::*, bs_ctrl_pkg::*; #(
	parameter int NITER_W = NITER_W_DEFAULT
) (
	input logic clk,
	input logic nreset,
	input cmd_t cmd,
	input logic [NITER_W-1:0] niter,
	input logic done,
	input strike_t const_k,
	input drift_t const1,
	input vol_t const2,
	input grn_t grn,
	output state_t status,
	output logic start,
	output logic [NITER_W-1:0] niter_q,
	cfg_if.ctrl cfg
);

	state_t next_state;

	// Next state.
	// Only RUN in idle and ACK in complete have an effect.
	always_comb begin
		next_state = status;
		case (status)
			ST_IDLE: begin
				if (cmd == CMD_RUN) begin
					next_state = ST_RUNNING;
				end
			end
			ST_RUNNING: begin
				// Accumulator reports the final beat.
				if (done) begin
					next_state = ST_COMPLETE;
				end
			end
			ST_COMPLETE: begin
				if (cmd == CMD_ACK) begin
					next_state = ST_IDLE;
				end
			end
			default: begin
				next_state = ST_IDLE;
			end
		endcase
	end

	// State register and start pulse.
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			status <= ST_IDLE;
			start <= 1'b0;
		end else begin
			status <= next_state;
			// One cycle, on leaving idle.
			start <= (status == ST_IDLE) && (cmd == CMD_RUN);
		end
	end

	// Track inputs while idle, hold them for the run.
	always_ff @(posedge clk) begin
		if (status == ST_IDLE) begin
			niter_q <= niter;
			cfg.strike <= const_k;
			cfg.drift <= const1;
			cfg.vol <= const2;
			cfg.grn <= grn;
		end
	end

endmodule

`default_nettype wire

// File: hw/iteration_counter.sv
`default_nettype none

module iteration_counter import bs_ctrl_pkg::*; #(
	parameter int NITER_W = NITER_W_DEFAULT
) (
	input logic clk,
	input logic nreset,
	input logic start,
	input logic [NITER_W-1:0] niter_q,
	output logic issue,
	output logic last
);

	// Samples still to issue.
	logic [NITER_W-1:0] remaining;
	// Set from start until the final issue.
	logic active;

	// Zero count gives one cycle with last only.
	assign issue = active && (remaining != '0);
	assign last = active && (remaining <= NITER_W'(1));

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			remaining <= '0;
			active <= 1'b0;
		end else if (start) begin
			remaining <= niter_q;
			active <= 1'b1;
		end else if (active) begin
			remaining <= remaining - NITER_W'(1);
			// Final or empty cycle.
			if (remaining <= NITER_W'(1)) begin
				active <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/payoff_accumulator.sv
`default_nettype none

module payoff_accumulator import bs_fixed_pkg::*; (
	input logic clk,
	input logic nreset,
	input logic start,
	cfg_if.acc cfg,
	price_if.dst price,
	output sum_t sum,
	output logic done
);

	// Price and strike at 15 fraction bits, widened for the compare.
	logic signed [49:0] price_wide;
	logic signed [49:0] strike_wide;
	// Value taken off the strike.
	strike_t operand;
	strike_t diff_q;
	logic valid1_q;
	logic last1_q;

	assign price_wide = {1'b0, price.price[94:46]};
	assign strike_wide = cfg.strike;

	// Clamp.
	always_comb begin
		if (price.range == RANGE_LOW) begin
			operand = '0;
		end else if ((price.range == RANGE_HIGH) || (price_wide > strike_wide)) begin
			operand = cfg.strike;
		end else begin
			// Price in (8,15).
			operand = price.price[68:46];
		end
	end

	// Per-sample payoff.
	always_ff @(posedge clk) begin
		diff_q <= cfg.strike - operand;
	end

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			valid1_q <= 1'b0;
			last1_q <= 1'b0;
			done <= 1'b0;
			sum <= '0;
		end else begin
			valid1_q <= price.valid;
			last1_q <= price.last;
			// Final payoff lands in the same cycle.
			done <= last1_q;
			if (start) begin
				sum <= '0;
			end else if (valid1_q) begin
				sum <= sum + {41'b0, diff_q};
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/bs_processor.sv
`default_nettype none

module bs_processor import bs_fixed_pkg::*, bs_ctrl_pkg::*; #(
	parameter int NITER_W = NITER_W_DEFAULT
) (
	input logic clk,
	input logic nreset,
	input logic [NITER_W-1:0] niter,
	input cmd_t cmd,
	input strike_t const_k,
	input drift_t const1,
	input vol_t const2,
	input grn_t grn,
	output state_t status,
	output sum_t sum
);

	// Control pulses.
	logic start;
	logic issue;
	logic last;
	logic done;
	// Latched iteration count.
	logic [NITER_W-1:0] niter_q;

	cfg_if i_cfg_if ();
	price_if i_price_if ();

	// Command FSM and constant latches.
	run_control #(
		.NITER_W(NITER_W)
	) i_run_control (
		.clk(clk),
		.nreset(nreset),
		.cmd(cmd),
		.niter(niter),
		.done(done),
		.const_k(const_k),
		.const1(const1),
		.const2(const2),
		.grn(grn),
		.status(status),
		.start(start),
		.niter_q(niter_q),
		.cfg(i_cfg_if.ctrl)
	);

	// One sample per cycle.
	iteration_counter #(
		.NITER_W(NITER_W)
	) i_iteration_counter (
		.clk(clk),
		.nreset(nreset),
		.start(start),
		.niter_q(niter_q),
		.issue(issue),
		.last(last)
	);

	// Three cycles from issue to price.
	exp_pipeline i_exp_pipeline (
		.clk(clk),
		.nreset(nreset),
		.issue(issue),
		.last(last),
		.cfg(i_cfg_if.pipe),
		.price(i_price_if.src)
	);

	// Clamp, subtract and sum.
	payoff_accumulator i_payoff_accumulator (
		.clk(clk),
		.nreset(nreset),
		.start(start),
		.cfg(i_cfg_if.acc),
		.price(i_price_if.dst),
		.sum(sum),
		.done(done)
	);

endmodule

`default_nettype wire

// File: testbench/bs_processor_assertions.sv
`default_nettype none

module bs_processor_assertions import bs_ctrl_pkg::*, bs_fixed_pkg::*; (
	input logic clk,
	input logic nreset,
	input state_t status,
	input sum_t sum
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failed assertions so far, read by the testbench.
	int unsigned error_count = 0;

	// Only the three defined states.
	status_legal: assert property (@(posedge clk) disable iff (!nreset)
		status inside {ST_IDLE, ST_RUNNING, ST_COMPLETE})
		else begin
			$error("status holds an undefined state");
			error_count++;
		end

	// Result is frozen for the host while complete.
	sum_held_in_complete: assert property (@(posedge clk) disable iff (!nreset)
		(status == ST_COMPLETE) ##1 (status == ST_COMPLETE) |-> $stable(sum))
		else begin
			$error("sum changed while status is complete");
			error_count++;
		end

	// A run is entered from idle only.
	running_from_idle: assert property (@(posedge clk) disable iff (!nreset)
		(status == ST_RUNNING) && (status != $past(status)) |-> $past(status) == ST_IDLE)
		else begin
			$error("status entered running from a state other than idle");
			error_count++;
		end

endmodule

// Attach to every instance of the top level.
bind bs_processor bs_processor_assertions i_bs_processor_assertions (
	.clk(clk),
	.nreset(nreset),
	.status(status),
	.sum(sum)
);

`default_nettype wire

// File: testbench/tb_bs_processor.sv
`default_nettype none

module tb_bs_processor import bs_fixed_pkg::*, bs_ctrl_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int NITER_W = NITER_W_DEFAULT;

	// DUT ports.
	logic clk;
	logic nreset;
	logic [NITER_W-1:0] niter;
	cmd_t cmd;
	strike_t const_k;
	drift_t const1;
	vol_t const2;
	grn_t grn;
	state_t status;
	sum_t sum;

	// Vectors, one entry per run.
	int unsigned vec_niter[$];
	strike_t vec_k[$];
	drift_t vec_drift[$];
	vol_t vec_vol[$];
	grn_t vec_grn[$];
	sum_t vec_sum[$];

	// Run limit.
	int cycle_count = 0;
	int timeout_limit = 0;
	int runs_done = 0;

	bs_processor #(
		.NITER_W(NITER_W)
	) i_bs_processor (
		.clk(clk),
		.nreset(nreset),
		.niter(niter),
		.cmd(cmd),
		.const_k(const_k),
		.const1(const1),
		.const2(const2),
		.grn(grn),
		.status(status),
		.sum(sum)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_sum(input sum_t actual, input sum_t expected, input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_status(input state_t actual, input state_t expected,
			input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got %0d, expected %0d", $time, what, actual,
				expected);
			abort_run();
		end
	endtask

	// Comment and blank lines are skipped.
	task automatic read_vectors();
		int fd;
		int count;
		string line;
		int unsigned f_niter;
		strike_t f_k;
		drift_t f_drift;
		vol_t f_vol;
		grn_t f_grn;
		sum_t f_sum;
		fd = $fopen("testbench/bs_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file testbench/bs_vectors.txt");
			abort_run();
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line[0] != "#" && line[0] != "\n" && line[0] != "\r") begin
					count = $sscanf(line, "%d %h %h %h %h %h", f_niter, f_k, f_drift, f_vol,
						f_grn, f_sum);
					if (count != 6) begin
						$display("a vector line could not be parsed: %s", line);
						abort_run();
					end else begin
						vec_niter.push_back(f_niter);
						vec_k.push_back(f_k);
						vec_drift.push_back(f_drift);
						vec_vol.push_back(f_vol);
						vec_grn.push_back(f_grn);
						vec_sum.push_back(f_sum);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// Sampled away from the driving edge.
	task automatic wait_complete();
		do begin
			@(negedge clk);
		end while (status == ST_RUNNING);
		check_status(status, ST_COMPLETE, "status at end of run");
	endtask

	// One full run, then the ignored commands and ACK.
	task automatic run_vector(input int idx);
		@(posedge clk);
		niter <= NITER_W'(vec_niter[idx]);
		const_k <= vec_k[idx];
		const1 <= vec_drift[idx];
		const2 <= vec_vol[idx];
		grn <= vec_grn[idx];
		@(posedge clk);
		cmd <= CMD_RUN;
		@(posedge clk);
		cmd <= CMD_NONE;
		@(negedge clk);
		check_status(status, ST_RUNNING, "status one cycle after RUN");
		wait_complete();
		check_sum(sum, vec_sum[idx], $sformatf("sum of vector %0d", idx));
		// RUN and an undefined code are ignored in complete.
		@(posedge clk);
		cmd <= CMD_RUN;
		@(posedge clk);
		cmd <= cmd_t'(4'hF);
		@(posedge clk);
		cmd <= CMD_NONE;
		@(negedge clk);
		check_status(status, ST_COMPLETE, "status after ignored commands");
		check_sum(sum, vec_sum[idx], "sum after ignored commands");
		@(posedge clk);
		cmd <= CMD_ACK;
		@(posedge clk);
		cmd <= CMD_NONE;
		@(negedge clk);
		check_status(status, ST_IDLE, "status one cycle after ACK");
		check_sum(sum, vec_sum[idx], "sum held in idle");
		// ACK in idle has no effect.
		@(posedge clk);
		cmd <= CMD_ACK;
		@(posedge clk);
		cmd <= CMD_NONE;
		@(negedge clk);
		check_status(status, ST_IDLE, "status after ACK in idle");
	endtask

	// Timeout watchdog.
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if ((timeout_limit > 0) && (cycle_count >= timeout_limit)) begin
			$display("timeout: the runs did not finish within %0d cycles", timeout_limit);
			abort_run();
		end
	end

	// A failed bound assertion ends the run.
	always @(i_bs_processor.i_bs_processor_assertions.error_count) begin
		if (i_bs_processor.i_bs_processor_assertions.error_count != 0) begin
			$display("an assertion bound to the DUT failed");
			abort_run();
		end
	end

	initial begin
		nreset = 1'b0;
		niter = '0;
		cmd = CMD_NONE;
		const_k = '0;
		const1 = '0;
		const2 = '0;
		grn = '0;
		read_vectors();
		// Budget per run plus margin.
		foreach (vec_niter[i]) begin
			timeout_limit += vec_niter[i] + 20;
		end
		timeout_limit += 100;
		repeat (3) @(posedge clk);
		nreset <= 1'b1;
		@(negedge clk);
		check_status(status, ST_IDLE, "status after reset");
		check_sum(sum, '0, "sum after reset");
		foreach (vec_niter[i]) begin
			run_vector(i);
			runs_done++;
		end
		if (runs_done == 0) begin
			$display("no vectors were found in the vector file");
			abort_run();
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
common/bs_fixed_pkg.sv
common/bs_ctrl_pkg.sv
common/bs_if.sv
exp_pipeline/exp_lut.sv
exp_pipeline/exp_pipeline.sv
hw/run_control.sv
hw/iteration_counter.sv
hw/payoff_accumulator.sv
hw/bs_processor.sv
testbench/bs_processor_assertions.sv
testbench/tb_bs_processor.sv

// File: Bender.yml
package:
  name: bs_processor

sources:
  # Shared packages and interfaces.
  - common/bs_fixed_pkg.sv
  - common/bs_ctrl_pkg.sv
  - common/bs_if.sv
  # Exponential datapath.
  - exp_pipeline/exp_lut.sv
  - exp_pipeline/exp_pipeline.sv
  # Control, accumulation and top level.
  - hw/run_control.sv
  - hw/iteration_counter.sv
  - hw/payoff_accumulator.sv
  - hw/bs_processor.sv
  # Testbench and bound assertions.
  - target: simulation
    files:
      - testbench/bs_processor_assertions.sv
      - testbench/tb_bs_processor.sv

// File: testbench/bs_vectors.txt
# niter (decimal), then hex: const_k (8,15), const1 drift (23,15), const2 vol (3,15),
# grn (5,15) two's complement, expected sum (40,15).
4 50000 0040000 08000 00000 0000000000040000
3 10000 0008000 02000 08000 00000000000112F2
2 10000 0008000 02000 0C000 0000000000008E34
5 50000 0008000 08000 30000 0000000000000000
4 18000 0008000 10000 B0000 0000000000060000
3 50000 0060000 08000 00000 0000000000000000
0 50000 0040000 08000 00000 0000000000000000
